// File: Makefile
# Verilator build and run for the complex arithmetic datapath
# override any variable on the command line, e.g. make JOBS=8

VERILATOR ?= verilator
TOP       ?= tb_complex_proc
RTL_TOP   ?= complex_proc_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter src/%,$(SRCS))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
	rm -f $(LOG)

// File: filelist.f
src/cplx_pkg.sv
src/alu.sv
src/inst_decoder.sv
src/complex_alu.sv
src/complex_proc_top.sv
verification/tb_complex_proc.sv

// File: src/alu.sv
`timescale 1ns/1ps

module alu import cplx_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic [PORTA_WIDTH-1:0] a_i,       // sign-extended operand
	input  logic [PORTB_WIDTH-1:0] b_i,       // sign-extended operand
	input  logic                   cea2_i,    // a2 load enable
	input  logic                   ceb2_i,    // b2 load enable
	input  logic                   cep_i,     // p load enable
	input  xsel_e                  xsel_i,    // x mux select, p stage
	input  zsel_e                  zsel_i,    // z mux select, p stage
	input  alumode_e               alumode_i, // add or subtract, p stage
	output logic [PORTP_WIDTH-1:0] p_o
);

	////////////////////////////////////////////////////////////
	// operand and product registers
	////////////////////////////////////////////////////////////

	logic signed [PORTA_WIDTH-1:0] a2_q; // a2 stage
	logic signed [PORTB_WIDTH-1:0] b2_q; // b2 stage
	logic signed [PORTP_WIDTH-1:0] m_q;  // product register
	logic signed [PORTP_WIDTH-1:0] p_q;  // accumulator

	logic signed [PORTP_WIDTH-1:0] x_mux;
	logic signed [PORTP_WIDTH-1:0] z_mux;
	logic signed [PORTP_WIDTH-1:0] alu_res;

	// edge 1
	always_ff @(posedge clk) begin
		if (cea2_i) begin
			a2_q <= a_i;
		end
		if (ceb2_i) begin
			b2_q <= b_i;
		end
	end

	// edge 2, free running so several items can be in flight
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			m_q <= '0;
		end else begin
			m_q <= a2_q * b2_q; // 30x18 fits in 48 bits
		end
	end

	////////////////////////////////////////////////////////////
	// x / z muxes and post-adder
	////////////////////////////////////////////////////////////

	always_comb begin
		case (xsel_i)
			X_MULT:  x_mux = m_q;
			default: x_mux = '0; // X_ZERO
		endcase
	end

	always_comb begin
		case (zsel_i)
			Z_P:     z_mux = p_q; // accumulate
			default: z_mux = '0;  // Z_ZERO, new result
		endcase
	end

	always_comb begin
		case (alumode_i)
			ALU_SUB: alu_res = z_mux - x_mux;
			default: alu_res = z_mux + x_mux; // ALU_ADD
		endcase
	end

	// edge 3, holds between instructions
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			p_q <= '0;
		end else if (cep_i) begin
			p_q <= alu_res;
		end
	end

	assign p_o = p_q;

endmodule

// File: src/complex_alu.sv
`timescale 1ns/1ps

module complex_alu import cplx_pkg::*; #(
	parameter int FRAC_BITS = 15 // binary point of the products
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic [2*DATA_WIDTH-1:0]   din_1_i,     // x, real in upper half
	input  logic [2*DATA_WIDTH-1:0]   din_2_i,     // y, real in upper half
	input  logic                [3:0] cea2_i,      // core_1 at bit 3
	input  logic                [3:0] ceb2_i,
	input  logic                [3:0] cep_i,
	input  xsel_e               [3:0] xsel_i,
	input  zsel_e               [3:0] zsel_i,
	input  alumode_e            [3:0] alumode_i,
	input  logic                      out_valid_i,
	output logic [2*DATA_WIDTH-1:0]   dout_o,      // {I, Q}
	output logic                      valid_o
);

	localparam int A_EXT = PORTA_WIDTH - DATA_WIDTH;
	localparam int B_EXT = PORTB_WIDTH - DATA_WIDTH;
	localparam int RND_W = PORTP_WIDTH + 2; // sum plus rounding headroom
	localparam int RND_BIT = (FRAC_BITS > 0) ? FRAC_BITS - 1 : 0;

	localparam logic signed [RND_W-1:0] ROUND   = (FRAC_BITS > 0) ? (1 << RND_BIT) : 0;
	localparam logic signed [RND_W-1:0] SAT_MAX = (1 << (DATA_WIDTH - 1)) - 1;
	localparam logic signed [RND_W-1:0] SAT_MIN = -(1 << (DATA_WIDTH - 1));

	logic [DATA_WIDTH-1:0]  xr, xi, yr, yi;
	logic [PORTA_WIDTH-1:0] a_xr, a_xi; // x parts on the a ports
	logic [PORTB_WIDTH-1:0] b_yr, b_yi; // y parts on the b ports

	logic signed [PORTP_WIDTH-1:0] p_1, p_2, p_3, p_4;
	logic signed [RND_W-1:0]       i_sum, q_sum;

	logic [2*DATA_WIDTH-1:0] dout_q;
	logic                    valid_q;

	// half-up rounding at FRAC_BITS, then clamp to 16-bit signed
	function automatic logic [DATA_WIDTH-1:0] round_sat(input logic signed [RND_W-1:0] s);
		logic signed [RND_W-1:0] r;
		r = (s + ROUND) >>> FRAC_BITS;
		if (r > SAT_MAX) begin
			r = SAT_MAX;
		end else if (r < SAT_MIN) begin
			r = SAT_MIN;
		end
		return r[DATA_WIDTH-1:0];
	endfunction

	////////////////////////////////////////////////////////////
	// operand routing
	////////////////////////////////////////////////////////////

	assign xr = din_1_i[2*DATA_WIDTH-1:DATA_WIDTH];
	assign xi = din_1_i[DATA_WIDTH-1:0];
	assign yr = din_2_i[2*DATA_WIDTH-1:DATA_WIDTH];
	assign yi = din_2_i[DATA_WIDTH-1:0];

	assign a_xr = {{A_EXT{xr[DATA_WIDTH-1]}}, xr};
	assign a_xi = {{A_EXT{xi[DATA_WIDTH-1]}}, xi};
	assign b_yr = {{B_EXT{yr[DATA_WIDTH-1]}}, yr};
	assign b_yi = {{B_EXT{yi[DATA_WIDTH-1]}}, yi};

	alu core_1 ( // xr * yr
		.clk(clk), .rst_n_i(rst_n_i), .a_i(a_xr), .b_i(b_yr),
		.cea2_i(cea2_i[3]), .ceb2_i(ceb2_i[3]), .cep_i(cep_i[3]),
		.xsel_i(xsel_i[3]), .zsel_i(zsel_i[3]), .alumode_i(alumode_i[3]),
		.p_o(p_1)
	);

	alu core_2 ( // xi * yi
		.clk(clk), .rst_n_i(rst_n_i), .a_i(a_xi), .b_i(b_yi),
		.cea2_i(cea2_i[2]), .ceb2_i(ceb2_i[2]), .cep_i(cep_i[2]),
		.xsel_i(xsel_i[2]), .zsel_i(zsel_i[2]), .alumode_i(alumode_i[2]),
		.p_o(p_2)
	);

	alu core_3 ( // xr * yi
		.clk(clk), .rst_n_i(rst_n_i), .a_i(a_xr), .b_i(b_yi),
		.cea2_i(cea2_i[1]), .ceb2_i(ceb2_i[1]), .cep_i(cep_i[1]),
		.xsel_i(xsel_i[1]), .zsel_i(zsel_i[1]), .alumode_i(alumode_i[1]),
		.p_o(p_3)
	);

	alu core_4 ( // xi * yr
		.clk(clk), .rst_n_i(rst_n_i), .a_i(a_xi), .b_i(b_yr),
		.cea2_i(cea2_i[0]), .ceb2_i(ceb2_i[0]), .cep_i(cep_i[0]),
		.xsel_i(xsel_i[0]), .zsel_i(zsel_i[0]), .alumode_i(alumode_i[0]),
		.p_o(p_4)
	);

	////////////////////////////////////////////////////////////
	// combine, round, saturate
	////////////////////////////////////////////////////////////

	assign i_sum = p_1 + p_2; // signs already applied in the cores
	assign q_sum = p_3 + p_4;

	always_ff @(posedge clk) begin
		if (out_valid_i) begin
			dout_q <= {round_sat(i_sum), round_sat(q_sum)}; // edge 4
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= out_valid_i;
		end
	end

	assign dout_o  = dout_q;
	assign valid_o = valid_q;

endmodule

// File: src/complex_proc_top.sv
`timescale 1ns/1ps

module complex_proc_top import cplx_pkg::*; #(
	parameter int FRAC_BITS = 15 // Q15 by default
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    valid_i, // instruction strobe
	input  op_e                     op_i,
	input  logic [2*DATA_WIDTH-1:0] x_i,     // {re, im}
	input  logic [2*DATA_WIDTH-1:0] y_i,     // {re, im}
	output logic                    valid_o, // 4 cycles after valid_i
	output logic [2*DATA_WIDTH-1:0] z_o      // {I, Q}
);

	logic     [3:0] cea2, ceb2, cep; // per-core enables
	xsel_e    [3:0] xsel;
	zsel_e    [3:0] zsel;
	alumode_e [3:0] alumode;
	logic           out_valid;

	inst_decoder decoder_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.op_i(op_i),
		.cea2_o(cea2),
		.ceb2_o(ceb2),
		.cep_o(cep),
		.xsel_o(xsel),
		.zsel_o(zsel),
		.alumode_o(alumode),
		.out_valid_o(out_valid)
	);

	complex_alu #(
		.FRAC_BITS(FRAC_BITS)
	) complex_alu_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.din_1_i(x_i), .din_2_i(y_i), // operands straight in
		.cea2_i(cea2), .ceb2_i(ceb2), .cep_i(cep),
		.xsel_i(xsel), .zsel_i(zsel), .alumode_i(alumode),
		.out_valid_i(out_valid),
		.dout_o(z_o),
		.valid_o(valid_o)
	);

endmodule

// File: src/cplx_pkg.sv
package cplx_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH  = 16; // one real or imag part, Q15
	localparam int PORTA_WIDTH = 30; // core a port
	localparam int PORTB_WIDTH = 18; // core b port
	localparam int PORTP_WIDTH = 48; // core p port / accumulator

	////////////////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_NOP   = 3'd0, // no instruction
		OP_CMUL  = 3'd1, // x * y
		OP_CMULC = 3'd2, // x * conj(y)
		OP_CMAC  = 3'd3, // acc += x * y
		OP_CMACC = 3'd4  // acc += x * conj(y)
	} op_e;

	////////////////////////////////////////////////////////////
	// per-core mode fields
	////////////////////////////////////////////////////////////

	typedef enum logic {
		X_ZERO = 1'b0, // x operand forced to zero
		X_MULT = 1'b1  // x operand from m register
	} xsel_e;

	typedef enum logic {
		Z_ZERO = 1'b0, // restart accumulation
		Z_P    = 1'b1  // p feedback
	} zsel_e;

	typedef enum logic {
		ALU_ADD = 1'b0, // z + x
		ALU_SUB = 1'b1  // z - x
	} alumode_e;

endpackage

// File: src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import cplx_pkg::*; (
	input  logic           clk,
	input  logic           rst_n_i,
	input  logic           valid_i,     // one instruction per strobe
	input  op_e            op_i,
	output logic     [3:0] cea2_o,      // core_1 at bit 3
	output logic     [3:0] ceb2_o,
	output logic     [3:0] cep_o,       // two cycles after valid_i
	output xsel_e    [3:0] xsel_o,      // p stage aligned
	output zsel_e    [3:0] zsel_o,
	output alumode_e [3:0] alumode_o,
	output logic           out_valid_o  // rounding register load
);

	logic       take;      // valid non-nop instruction
	logic [3:0] sub_pat;   // per-core subtract, core_1 at bit 3
	logic       acc;       // accumulate onto p
	logic [2:0] valid_sr;  // stage valids

	xsel_e    [3:0] xsel_d,    xsel_q1,    xsel_q2;
	zsel_e    [3:0] zsel_d,    zsel_q1,    zsel_q2;
	alumode_e [3:0] alumode_d, alumode_q1, alumode_q2;

	assign take   = valid_i && (op_i != OP_NOP);
	assign cea2_o = {4{take}}; // operands load on the valid_i edge
	assign ceb2_o = {4{take}};

	////////////////////////////////////////////////////////////
	// opcode to per-core modes
	////////////////////////////////////////////////////////////

	always_comb begin
		case (op_i)
			OP_CMUL: begin
				sub_pat = 4'b0100; // I = rr - ii, Q = ri + ir
				acc     = 1'b0;
			end
			OP_CMULC: begin
				sub_pat = 4'b0010; // I = rr + ii, Q = ir - ri
				acc     = 1'b0;
			end
			OP_CMAC: begin
				sub_pat = 4'b0100;
				acc     = 1'b1;
			end
			OP_CMACC: begin
				sub_pat = 4'b0010;
				acc     = 1'b1;
			end
			default: begin
				sub_pat = 4'b0000;
				acc     = 1'b0;
			end
		endcase
		for (int k = 0; k < 4; k++) begin
			xsel_d[k]    = take ? X_MULT : X_ZERO;
			zsel_d[k]    = acc ? Z_P : Z_ZERO;
			alumode_d[k] = sub_pat[k] ? ALU_SUB : ALU_ADD;
		end
	end

	////////////////////////////////////////////////////////////
	// stage delays
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_sr <= '0;
			for (int k = 0; k < 4; k++) begin
				xsel_q1[k]    <= X_ZERO;
				xsel_q2[k]    <= X_ZERO;
				zsel_q1[k]    <= Z_ZERO;
				zsel_q2[k]    <= Z_ZERO;
				alumode_q1[k] <= ALU_ADD;
				alumode_q2[k] <= ALU_ADD;
			end
		end else begin
			valid_sr   <= {valid_sr[1:0], take}; // a2/b2, m, p stages
			xsel_q1    <= xsel_d;    // m stage
			xsel_q2    <= xsel_q1;   // p stage
			zsel_q1    <= zsel_d;
			zsel_q2    <= zsel_q1;
			alumode_q1 <= alumode_d;
			alumode_q2 <= alumode_q1;
		end
	end

	assign cep_o       = {4{valid_sr[1]}}; // p loads on edge 3
	assign xsel_o      = xsel_q2;
	assign zsel_o      = zsel_q2;
	assign alumode_o   = alumode_q2;
	assign out_valid_o = valid_sr[2];      // output reg on edge 4

endmodule

// File: verification/tb_complex_proc.sv
`timescale 1ns/1ps

module tb_complex_proc import cplx_pkg::*; ();

	localparam int FRAC_BITS    = 15;   // Q15
	localparam int CLK_PERIOD   = 100;  // ns
	localparam int DRIVE_DELAY  = 10;   // ns after rising edge
	localparam int RESET_CYCLES = 5;
	localparam int MAX_CYCLES   = 2000; // sequence is a few hundred cycles
	localparam int N_CMUL       = 100;
	localparam int N_CMULC      = 50;
	localparam int N_CHAIN      = 24;

	logic                    clk;
	logic                    rst_n_i;
	logic                    valid_i;
	op_e                     op_i;
	logic [2*DATA_WIDTH-1:0] x_i;
	logic [2*DATA_WIDTH-1:0] y_i;
	logic                    valid_o;
	logic [2*DATA_WIDTH-1:0] z_o;

	logic                          in_take;       // instruction sampled at next edge
	int                            cycle_cnt = 0;
	logic [31:0]                   lfsr_q;        // stimulus state
	logic signed [PORTP_WIDTH-1:0] acc_m [4];     // model accumulators with core 1 at 0
	logic [2*DATA_WIDTH-1:0]       exp_q [$];     // results in flight
	logic [2*DATA_WIDTH-1:0]       exp_z;         // result due at next edge

	assign in_take = valid_i && (op_i != OP_NOP);

	complex_proc_top #(
		.FRAC_BITS(FRAC_BITS)
	) complex_proc_top_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.op_i(op_i),
		.x_i(x_i),
		.y_i(y_i),
		.valid_o(valid_o),
		.z_o(z_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// failure handling
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		abort_run($sformatf("FAILED at %0d ns: %s expected %h, got %h",
			$time, name, exp_v, act_v));
	endtask

	////////////////////////////////////////////////////////////
	// stimulus source
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hA300_0000; // right-shift galois taps
		end else begin
			return s >> 1;
		end
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic [DATA_WIDTH-1:0] round_sat16(input logic signed [63:0] s);
		logic signed [63:0] r;
		r = s + (64'sd1 <<< (FRAC_BITS - 1)); // half up
		r = r >>> FRAC_BITS;
		if (r > 64'sd32767) begin
			return 16'h7fff;
		end else if (r < -64'sd32768) begin
			return 16'h8000;
		end else begin
			return r[DATA_WIDTH-1:0];
		end
	endfunction

	// one instruction through the per-core accumulators
	function automatic logic [31:0] model_step(input op_e op, input logic [31:0] x,
			input logic [31:0] y);
		logic signed [DATA_WIDTH-1:0]  xr, xi, yr, yi;
		logic signed [PORTP_WIDTH-1:0] prod [4];
		logic [3:0]                    neg;   // minus per core with core 1 at bit 0
		logic                          accum;
		logic signed [63:0]            i_s, q_s;
		xr = x[31:16];
		xi = x[15:0];
		yr = y[31:16];
		yi = y[15:0];
		prod[0] = xr * yr;
		prod[1] = xi * yi;
		prod[2] = xr * yi;
		prod[3] = xi * yr;
		accum = (op == OP_CMAC) || (op == OP_CMACC);
		if (op == OP_CMULC || op == OP_CMACC) begin
			neg = 4'b0100; // conj y makes core 3 subtract
		end else begin
			neg = 4'b0010; // core 2 subtracts
		end
		for (int k = 0; k < 4; k++) begin
			if (accum) begin
				acc_m[k] = neg[k] ? acc_m[k] - prod[k] : acc_m[k] + prod[k];
			end else begin
				acc_m[k] = neg[k] ? -prod[k] : prod[k]; // restart
			end
		end
		i_s = 64'(acc_m[0]) + 64'(acc_m[1]);
		q_s = 64'(acc_m[2]) + 64'(acc_m[3]);
		return {round_sat16(i_s), round_sat16(q_s)};
	endfunction

	// inputs and outputs are both stable here
	always @(negedge clk) begin
		if (rst_n_i) begin
			if (valid_o === 1'b1) begin
				if (exp_q.size() == 0) begin
					abort_run("valid_o went high with no instruction in flight");
				end else begin
					exp_z = exp_q.pop_front();
				end
			end
			if (in_take) begin
				exp_q.push_back(model_step(op_i, x_i, y_i));
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			abort_run($sformatf("timeout after %0d cycles with %0d results pending",
				cycle_cnt, exp_q.size()));
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk)
		(cycle_cnt >= 1 && $past(!rst_n_i)) |-> !valid_o)
	else report_mismatch("valid_o", 32'd0, {31'd0, $sampled(valid_o)});

	valid_timing: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o == $past(in_take, 4)) // one valid_o per instruction after 4 cycles
	else report_mismatch("valid_o", {31'd0, ~$sampled(valid_o)}, {31'd0, $sampled(valid_o)});

	data_match: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o |-> z_o == exp_z)
	else report_mismatch("z_o", $sampled(exp_z), $sampled(z_o));

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_op(input op_e op, input logic [31:0] x, input logic [31:0] y);
		@(posedge clk);
		#(DRIVE_DELAY);
		valid_i = 1'b1;
		op_i    = op;
		x_i     = x;
		y_i     = y;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#(DRIVE_DELAY);
		valid_i = 1'b0;
		op_i    = OP_CMAC;       // must be ignored without valid_i
		x_i     = rand_bits(32);
		y_i     = rand_bits(32);
	endtask

	task automatic send_random(input op_e op);
		logic [31:0] xv;
		logic [31:0] yv;
		xv = rand_bits(32);
		yv = rand_bits(32);
		drive_op(op, xv, yv);
	endtask

	initial begin
		rst_n_i = 1'b0;
		valid_i = 1'b0;
		op_i    = OP_NOP;
		x_i     = '0;
		y_i     = '0;
		lfsr_q  = 32'h4334_1aee;
		for (int k = 0; k < 4; k++) begin
			acc_m[k] = '0; // p registers clear on reset
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n_i = 1'b1;

		for (int i = 0; i < N_CMUL; i++) begin
			send_random(OP_CMUL); // back to back
		end
		drive_idle();
		drive_idle();
		for (int i = 0; i < N_CMULC; i++) begin
			send_random(OP_CMULC);
		end
		drive_idle();

		// accumulation with gaps and nops
		send_random(OP_CMUL);
		for (int i = 0; i < N_CHAIN; i++) begin
			case (i % 4)
				0:       send_random(OP_CMAC);
				1:       send_random(OP_CMACC);
				2:       drive_idle();
				default: send_random(OP_NOP);
			endcase
		end

		// full-scale operands drive both rails
		drive_op(OP_CMUL, 32'h8000_8000, 32'h8000_8000); // q at +full scale
		repeat (6) drive_op(OP_CMACC, 32'h8000_8000, 32'h8000_8000);
		drive_op(OP_CMUL, 32'h8000_8000, 32'h7fff_7fff); // q at -full scale
		repeat (6) drive_op(OP_CMAC, 32'h8000_8000, 32'h7fff_7fff);
		drive_idle();
		drive_idle();
		drive_op(OP_CMAC, 32'h8000_8000, 32'h7fff_7fff); // after gaps
		drive_idle();

		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (6) @(posedge clk); // no stray valid_o
		$display("Test OK");
		$finish;
	end

endmodule
